// File: flist.f
+incdir+tests
source/uart_cfg_pkg.sv
source/rx_word_pkg.sv
source/uart_rx_frame.sv
source/word_packer.sv
source/rx_word_fifo.sv
source/word_drain.sv
source/uart_word_rx.sv
tests/tb_uart_word_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the serial word receiver testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing \
  --top-module tb_uart_word_rx \
  -f flist.f \
  -o sim_tb 2>&1 | tee build.log

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failure"

// File: tests/uart_line_driver.svh
`ifndef UART_LINE_DRIVER_SVH
`define UART_LINE_DRIVER_SVH

// Serial line tasks. Every task is entered on a falling clock edge and
// returns on one, so rx only ever changes half a cycle away from sampling.

task automatic drive_bit(input logic value);
  rx = value;
  repeat (cfg.baud_div) @(negedge clk);
endtask

task automatic idle_bits(input int count);
  rx = 1'b1;
  repeat (count * BAUD_DIV) @(negedge clk);
endtask

// One frame: start bit, eight data bits LSB first, optional even parity, stop bit.
task automatic send_byte(
  input logic [7:0] data,
  input bit         bad_parity,
  input bit         bad_stop
);
  logic [7:0] shifted;
  logic       par;
  shifted = data;
  par = (^data) ^ bad_parity;           // Even parity, flipped on request.
  drive_bit(1'b0);
  repeat (8)
  begin
    drive_bit(shifted[0]);
    shifted = shifted >> 1;
  end
  if (cfg.parity_en)
    drive_bit(par);
  drive_bit(!bad_stop);
  if (bad_stop)
    idle_bits(1);                       // Lets the tail of the low stop bit read as a glitch.
endtask

// A low pulse too short to survive the mid start bit check.
task automatic send_glitch(input int low_cycles);
  rx = 1'b0;
  repeat (low_cycles) @(negedge clk);
  idle_bits(1);
endtask

`endif

// File: tests/tb_uart_word_rx.sv
module tb_uart_word_rx;

  localparam int BAUD_DIV = 8;
  localparam int FRAMES = 58;
  localparam int TIMEOUT_CYCLES = FRAMES * 11 * BAUD_DIV + 2000;
  localparam int EXTRA_NONE = 0;
  localparam int EXTRA_BAD_PARITY = 1;
  localparam int EXTRA_BAD_STOP = 2;
  localparam int EXTRA_GLITCH = 3;

  logic                      clk;
  logic                      nrst;
  logic                      rx;
  uart_cfg_pkg::uart_cfg_t   cfg;
  logic [31:0]               word_data;
  logic                      word_valid;
  logic                      word_ready;
  rx_word_pkg::rx_status_t   status;

  rx_word_pkg::rx_status_t   exp_status;
  logic [31:0]               exp_words [16];
  logic [3:0]                exp_wr;
  logic [3:0]                exp_rd = '0;
  logic                      check_now;
  logic                      expect_idle;
  integer                    seed;
  int                        errors = 0;
  int                        errors_at_start;
  int                        tests_passed;
  int                        tests_failed;
  int                        cycles;

  uart_word_rx UUT (
    .clk        (clk),
    .nrst       (nrst),
    .rx         (rx),
    .cfg        (cfg),
    .word_data  (word_data),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .status     (status)
  );

  `include "uart_line_driver.svh"

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (!nrst)
      exp_rd <= exp_wr;                 // Reset discards words still held in the DUT.
    else if (word_valid && word_ready && exp_rd != exp_wr)
      exp_rd <= exp_rd + 1'b1;
  end

  a_word_data: assert property (@(posedge clk) disable iff (!nrst)
    word_valid && word_ready && exp_rd != exp_wr |-> word_data == exp_words[exp_rd])
    else
    begin
      $display("ERR %0t: word 0x%08h, expected 0x%08h", $time, word_data, exp_words[exp_rd]);
      errors++;
    end

  a_word_expected: assert property (@(posedge clk) disable iff (!nrst)
    word_valid |-> exp_rd != exp_wr)
    else
    begin
      $display("At %0t the DUT offered a word that was never sent or should be dropped.", $time);
      errors++;
    end

  a_status_allowed: assert property (@(posedge clk) disable iff (!nrst)
    (status & ~exp_status) == 3'b000)
    else
    begin
      $display("ERR %0t: status %b raises a flag outside %b", $time, status, exp_status);
      errors++;
    end

  a_status_final: assert property (@(posedge clk) disable iff (!nrst)
    check_now |-> status == exp_status)
    else
    begin
      $display("ERR %0t: status %b, expected %b", $time, status, exp_status);
      errors++;
    end

  a_idle_after_reset: assert property (@(posedge clk) disable iff (!nrst)
    expect_idle |-> !word_valid && status == 3'b000)
    else
    begin
      $display("ERR %0t: valid %b status %b before the first word", $time, word_valid, status);
      errors++;
    end

  task automatic push_expected(input logic [31:0] word);
    exp_words[exp_wr] = word;
    exp_wr = exp_wr + 1'b1;
  endtask

  task automatic send_extra(input int kind, input logic [7:0] data);
    if (kind == EXTRA_BAD_PARITY)
      send_byte(data, 1'b1, 1'b0);
    else if (kind == EXTRA_BAD_STOP)
      send_byte(data, 1'b0, 1'b1);
    else if (kind == EXTRA_GLITCH)
      send_glitch(BAUD_DIV / 2 - 2);
  endtask

  // Four random bytes, with an optional corrupted frame slipped in before lane extra_at.
  task automatic send_word(input int extra_at, input int extra_kind, input bit keep);
    logic [31:0] word;
    logic [31:0] rnd;
    int          lane;
    word = '0;
    repeat (4)
    begin
      rnd = $random(seed);
      word = {rnd[7:0], word[31:8]};    // Byte n lands in bits 8n+7 down to 8n.
    end
    rnd = $random(seed);
    if (keep)
      push_expected(word);
    for (lane = 0; lane < 4; lane++)
    begin
      if (lane == extra_at)
        send_extra(extra_kind, rnd[7:0]);
      send_byte(word[7:0], 1'b0, 1'b0);
      word = word >> 8;
    end
  endtask

  task automatic reset_then_word();
    logic [31:0] word;
    logic [31:0] shifted;
    logic [31:0] rnd;
    int          lane;
    exp_status = '0;
    nrst = 1'b0;
    word_ready = 1'b1;
    repeat (3) @(negedge clk);
    nrst = 1'b1;
    expect_idle = 1'b1;
    word = '0;
    repeat (4)
    begin
      rnd = $random(seed);
      word = {rnd[7:0], word[31:8]};
    end
    shifted = word;
    for (lane = 0; lane < 4; lane++)
    begin
      if (lane == 3)
      begin
        expect_idle = 1'b0;             // The fourth byte completes the first word.
        push_expected(word);
      end
      send_byte(shifted[7:0], 1'b0, 1'b0);
      shifted = shifted >> 8;
    end
  endtask

  task automatic wait_drained();
    while (exp_rd != exp_wr)
      @(negedge clk);
    idle_bits(1);
  endtask

  task automatic check_status();
    check_now = 1'b1;
    @(negedge clk);
    check_now = 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial
  begin
    seed = 83;
    nrst = 1'b0;
    rx = 1'b1;
    cfg.baud_div = uart_cfg_pkg::BAUD_DIV_W'(BAUD_DIV);
    cfg.parity_en = 1'b0;
    word_ready = 1'b1;
    exp_status = '0;
    exp_wr = '0;
    check_now = 1'b0;
    expect_idle = 1'b0;
    errors_at_start = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(negedge clk);
    nrst = 1'b1;
    idle_bits(1);

    send_word(0, EXTRA_NONE, 1'b1);
    send_word(0, EXTRA_NONE, 1'b1);
    wait_drained();
    check_status();
    finish_test("plain bytes to words");

    cfg.parity_en = 1'b1;
    send_word(0, EXTRA_NONE, 1'b1);
    exp_status.parity_err = 1'b1;
    send_word(1, EXTRA_BAD_PARITY, 1'b1);
    wait_drained();
    check_status();
    finish_test("parity error");

    cfg.parity_en = 1'b0;
    exp_status.frame_err = 1'b1;
    send_word(2, EXTRA_BAD_STOP, 1'b1);
    wait_drained();
    check_status();
    finish_test("stop bit error");

    send_word(2, EXTRA_GLITCH, 1'b1);
    wait_drained();
    check_status();
    finish_test("start glitch");

    word_ready = 1'b0;
    repeat (5) send_word(0, EXTRA_NONE, 1'b1);
    exp_status.overrun = 1'b1;
    send_word(0, EXTRA_NONE, 1'b0);     // Sixth word finds no credit.
    check_status();
    word_ready = 1'b1;
    wait_drained();
    check_status();
    finish_test("back-pressure overrun");

    word_ready = 1'b0;
    send_word(0, EXTRA_NONE, 1'b1);     // Still waiting in the output register at reset.
    reset_then_word();
    wait_drained();
    check_status();
    finish_test("reset state");

    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles.", cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: source/uart_word_rx.sv
module uart_word_rx (
  input  logic                           clk,
  input  logic                           nrst,
  input  logic                           rx,
  input  uart_cfg_pkg::uart_cfg_t        cfg,
  output logic [rx_word_pkg::WORD_W-1:0] word_data,
  output logic                           word_valid,
  input  logic                           word_ready,
  output rx_word_pkg::rx_status_t        status
);

  uart_cfg_pkg::rx_byte_t         rx_byte;
  logic                           parity_err;
  logic                           frame_err;
  rx_word_pkg::word_push_t        push;
  logic                           pop;
  logic [rx_word_pkg::WORD_W-1:0] pop_data;
  logic                           not_empty;
  logic                           credit_return;

  uart_rx_frame u_frame (
    .clk        (clk),
    .nrst       (nrst),
    .rx         (rx),
    .cfg        (cfg),
    .byte_out   (rx_byte),
    .parity_err (parity_err),
    .frame_err  (frame_err)
  );

  word_packer u_packer (
    .clk           (clk),
    .nrst          (nrst),
    .byte_in       (rx_byte),
    .parity_err    (parity_err),
    .frame_err     (frame_err),
    .credit_return (credit_return),
    .push          (push),
    .status        (status)
  );

  rx_word_fifo u_fifo (
    .clk       (clk),
    .nrst      (nrst),
    .push      (push),
    .pop       (pop),
    .pop_data  (pop_data),
    .not_empty (not_empty)
  );

  word_drain u_drain (
    .clk           (clk),
    .nrst          (nrst),
    .pop_data      (pop_data),
    .not_empty     (not_empty),
    .word_ready    (word_ready),
    .pop           (pop),
    .credit_return (credit_return),
    .word_data     (word_data),
    .word_valid    (word_valid)
  );

endmodule

// File: source/word_drain.sv
module word_drain (
  input  logic                           clk,
  input  logic                           nrst,
  input  logic [rx_word_pkg::WORD_W-1:0] pop_data,
  input  logic                           not_empty,
  input  logic                           word_ready,
  output logic                           pop,
  output logic                           credit_return,
  output logic [rx_word_pkg::WORD_W-1:0] word_data,
  output logic                           word_valid
);

  // Refill when the register is free or emptying this cycle.
  assign pop = not_empty && (!word_valid || word_ready);
  assign credit_return = pop;             // Slot freed in the FIFO.

  always_ff @(posedge clk)
  begin
    if (!nrst)
      word_valid <= 1'b0;
    else if (pop)
      word_valid <= 1'b1;
    else if (word_ready)
      word_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      word_data <= pop_data;
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!nrst)
    word_valid && !word_ready |=> word_valid && $stable(word_data));

endmodule

// File: source/rx_word_fifo.sv
module rx_word_fifo (
  input  logic                          clk,
  input  logic                          nrst,
  input  rx_word_pkg::word_push_t       push,
  input  logic                          pop,
  output logic [rx_word_pkg::WORD_W-1:0] pop_data,
  output logic                          not_empty
);

  logic [rx_word_pkg::WORD_W-1:0]   mem [rx_word_pkg::FIFO_DEPTH];
  logic [rx_word_pkg::PTR_W-1:0]    wr_ptr;
  logic [rx_word_pkg::PTR_W-1:0]    rd_ptr;
  logic [rx_word_pkg::CREDIT_W-1:0] count;

  assign pop_data = mem[rd_ptr];        // Head is always on the output.
  assign not_empty = (count != '0);

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push.valid)
        wr_ptr <= wr_ptr + 1'b1;        // Depth is a power of two, pointers wrap.
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push.valid && !pop)
        count <= count + 1'b1;
      else if (!push.valid && pop)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push.valid)
      mem[wr_ptr] <= push.data;
  end

  // The packer only pushes while it holds a credit.
  a_no_overflow: assert property (@(posedge clk) disable iff (!nrst)
    push.valid |-> count != rx_word_pkg::CREDIT_MAX);

  a_no_underflow: assert property (@(posedge clk) disable iff (!nrst)
    pop |-> not_empty);

endmodule

// File: source/word_packer.sv
module word_packer (
  input  logic                    clk,
  input  logic                    nrst,
  input  uart_cfg_pkg::rx_byte_t  byte_in,
  input  logic                    parity_err,
  input  logic                    frame_err,
  input  logic                    credit_return,
  output rx_word_pkg::word_push_t push,
  output rx_word_pkg::rx_status_t status
);

  logic [rx_word_pkg::LANE_W-1:0]   lane;
  logic [rx_word_pkg::WORD_W-1:0]   word_q;
  logic [rx_word_pkg::WORD_W-1:0]   push_data;
  logic                             push_valid;
  logic [rx_word_pkg::CREDIT_W-1:0] credits;
  logic                             last_byte;
  logic                             spend;

  assign last_byte = byte_in.valid && (lane == rx_word_pkg::LAST_LANE);
  assign spend = last_byte && (credits != '0);

  assign push.valid = push_valid;
  assign push.data = push_data;

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      lane <= '0;
      push_valid <= 1'b0;
      credits <= rx_word_pkg::CREDIT_MAX;
      status <= '0;
    end
    else
    begin
      push_valid <= spend;
      if (byte_in.valid)
        lane <= lane + 1'b1;
      if (spend && !credit_return)
        credits <= credits - 1'b1;
      else if (!spend && credit_return)
        credits <= credits + 1'b1;
      if (parity_err)
        status.parity_err <= 1'b1;
      if (frame_err)
        status.frame_err <= 1'b1;
      if (last_byte && credits == '0)
        status.overrun <= 1'b1;        // Word is lost, FIFO has no room.
    end
  end

  always_ff @(posedge clk)
  begin
    if (byte_in.valid)
      word_q[lane*uart_cfg_pkg::DATA_BITS +: uart_cfg_pkg::DATA_BITS] <= byte_in.data;
    if (spend)
      push_data <= {byte_in.data,
                    word_q[rx_word_pkg::WORD_W-uart_cfg_pkg::DATA_BITS-1:0]};
  end

  a_credit_max: assert property (@(posedge clk) disable iff (!nrst)
    credits <= rx_word_pkg::CREDIT_MAX);

endmodule

// File: source/uart_rx_frame.sv
module uart_rx_frame (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    rx,
  input  uart_cfg_pkg::uart_cfg_t cfg,
  output uart_cfg_pkg::rx_byte_t  byte_out,
  output logic                    parity_err,
  output logic                    frame_err
);

  typedef enum logic [2:0] {
    s_idle,
    s_start,
    s_data,
    s_parity,
    s_stop
  } state_t;

  state_t                                 state;
  logic [uart_cfg_pkg::BAUD_DIV_W-1:0]    cnt;
  logic [uart_cfg_pkg::BIT_IDX_W-1:0]     bit_idx;
  logic [uart_cfg_pkg::DATA_BITS-1:0]     shift_q;
  logic                                   par_q;
  logic                                   valid_q;
  logic                                   tick;
  logic                                   start_seen;
  uart_cfg_pkg::uart_cfg_t                cfg_q;

  assign tick = (cnt == '0);            // Bit mid-point reached.
  assign start_seen = (state == s_idle) && !rx;

  assign byte_out.valid = valid_q;
  assign byte_out.data = shift_q;

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      state <= s_idle;
      cnt <= '0;
      bit_idx <= '0;
      par_q <= 1'b0;
      valid_q <= 1'b0;
      parity_err <= 1'b0;
      frame_err <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      parity_err <= 1'b0;
      frame_err <= 1'b0;
      if (state != s_idle && !tick)
        cnt <= cnt - 1'b1;
      case (state)
        s_idle:
        begin
          if (!rx)
          begin
            state <= s_start;
            cnt <= (cfg.baud_div >> 1) - 1'b1;  // Wait half a bit to land mid start bit.
          end
        end
        s_start:
        begin
          if (tick)
          begin
            if (!rx)
            begin
              state <= s_data;
              cnt <= cfg_q.baud_div - 1'b1;
              bit_idx <= '0;
              par_q <= 1'b0;
            end
            else
              state <= s_idle;              // Glitch, not a real start bit.
          end
        end
        s_data:
        begin
          if (tick)
          begin
            par_q <= par_q ^ rx;
            cnt <= cfg_q.baud_div - 1'b1;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == uart_cfg_pkg::BIT_IDX_W'(uart_cfg_pkg::DATA_BITS - 1))
              state <= cfg_q.parity_en ? s_parity : s_stop;
          end
        end
        s_parity:
        begin
          if (tick)
          begin
            par_q <= par_q ^ rx;            // Even parity leaves zero here.
            cnt <= cfg_q.baud_div - 1'b1;
            state <= s_stop;
          end
        end
        s_stop:
        begin
          if (tick)
          begin
            state <= s_idle;
            frame_err <= !rx;
            parity_err <= cfg_q.parity_en && par_q;
            valid_q <= rx && !(cfg_q.parity_en && par_q);
          end
        end
        default:
          state <= s_idle;
      endcase
    end
  end

  // Settings are frozen for the length of a frame.
  always_ff @(posedge clk)
  begin
    if (start_seen)
      cfg_q <= cfg;
    if (state == s_data && tick)
      shift_q <= {rx, shift_q[uart_cfg_pkg::DATA_BITS-1:1]};  // LSB arrives first.
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!nrst)
    byte_out.valid |=> !byte_out.valid);

  a_baud_min: assert property (@(posedge clk) disable iff (!nrst)
    state != s_idle |-> cfg_q.baud_div >= uart_cfg_pkg::BAUD_DIV_MIN);

endmodule

// File: source/rx_word_pkg.sv
package rx_word_pkg;

  localparam int WORD_W = 32;
  localparam int BYTES_PER_WORD = 4;
  localparam int LANE_W = $clog2(BYTES_PER_WORD);
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(BYTES_PER_WORD - 1);
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(FIFO_DEPTH);  // One credit per slot.

  // Word handed from the packer to the FIFO.
  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } word_push_t;

  // Sticky error flags, cleared only by reset.
  typedef struct packed {
    logic parity_err;
    logic frame_err;
    logic overrun;                        // A full word was lost for lack of a credit.
  } rx_status_t;

endpackage

// File: source/uart_cfg_pkg.sv
package uart_cfg_pkg;

  localparam int BAUD_DIV_W = 24;
  localparam int DATA_BITS = 8;
  localparam int BAUD_DIV_MIN = 4;      // Shortest bit period that still has a usable mid-point.
  localparam int BIT_IDX_W = $clog2(DATA_BITS);

  // Line settings as seen by the receiver.
  typedef struct packed {
    logic [BAUD_DIV_W-1:0] baud_div;    // Clock cycles per bit.
    logic                  parity_en;   // Even parity bit follows the data.
  } uart_cfg_t;

  // One received byte, valid for a single cycle.
  typedef struct packed {
    logic                 valid;
    logic [DATA_BITS-1:0] data;
  } rx_byte_t;

endpackage
